//--- files.f
source/nes_loader_pkg.sv
source/ines_header_parser.sv
source/rom_loader.sv
source/reset_sequencer.sv
source/joypad_serializer.sv
source/nes_loader_top.sv
testbench/tb_nes_loader.sv

//--- testbench/tb_nes_loader.sv
// NES loader testbench
// Loads iNES images through the host stream and checks ROM writes, mapper
// flags, console reset timing and both joypad serial ports
`timescale 1ns/1ps

module tb_nes_loader;
	import nes_loader_pkg::*;

	localparam int HOLD_CYCLES    = 16;
	localparam int TIMEOUT_CYCLES = 80000; // Two one-page images, PRG-only image, margin

	typedef struct packed {
		rom_addr_t addr;
		byte_t     data;
	} mem_write_t;

	logic          clk = 1'b0;
	logic          reset_nes;
	logic          downloading;
	logic          byte_valid;
	byte_t         byte_data;
	logic          invert_mirroring;
	logic          user_reset;
	pad_state_t    joy_a;
	pad_state_t    joy_b;
	pad_state_t    joy_c;
	pad_state_t    joy_d;
	logic          multitap_en;
	logic          swap_ports;
	logic          joypad_strobe;
	logic [1:0]    joypad_clock;
	rom_addr_t     mem_addr;
	byte_t         mem_data;
	logic          mem_write;
	mapper_flags_t mapper_flags;
	logic          loader_busy;
	logic          loader_done;
	logic          loader_error;
	logic          console_reset;
	logic [1:0]    joypad_data;

	mem_write_t    exp_writes [$]; // Reference model of the ROM writes
	byte_t         hdr [HEADER_BYTES];
	logic [15:0]   lfsr_q    = 16'd83;
	int            cycle_cnt = 0;

	nes_loader_top #(
		.DOWNLOAD_HOLD_CYCLES (HOLD_CYCLES)
	) i_dut (
		.clk (clk), .reset_nes (reset_nes),
		.downloading (downloading), .byte_valid (byte_valid), .byte_data (byte_data),
		.invert_mirroring (invert_mirroring), .user_reset (user_reset),
		.joy_a (joy_a), .joy_b (joy_b), .joy_c (joy_c), .joy_d (joy_d),
		.multitap_en (multitap_en), .swap_ports (swap_ports),
		.joypad_strobe (joypad_strobe), .joypad_clock (joypad_clock),
		.mem_addr (mem_addr), .mem_data (mem_data), .mem_write (mem_write),
		.mapper_flags (mapper_flags), .loader_busy (loader_busy),
		.loader_done (loader_done), .loader_error (loader_error),
		.console_reset (console_reset), .joypad_data (joypad_data)
	);

	always #10 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Error reporting and run limit

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
	                               input logic [31:0] actual);
		fail_run($sformatf("MISMATCH at %0t: %s expected %0h, actual %0h",
		                   $time, name, expected, actual));
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			fail_run($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
	end

	//////////////////////////////////////////////////////////////////////
	// Reference rules

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			b      = {b[6:0], lfsr_q[0]}; // One LFSR step per bit
		end
	endtask

	function automatic size_code_t size_class(input byte_t pages);
		int code;
		code = 0;
		while (code < 7 && (1 << code) < pages)
			code++;
		return size_code_t'(code);
	endfunction

	function automatic mapper_flags_t flags_from_header(input byte_t h [HEADER_BYTES],
	                                                    input logic inv);
		mapper_flags_t f;
		logic          nes2;
		logic          dirty;
		f     = '0;
		nes2  = (h[7][3:2] == 2'b10);
		dirty = (h[9][7:1] != 7'd0);
		for (int i = 10; i < HEADER_BYTES; i++)
			if (h[i] != 8'h00)
				dirty = 1'b1;
		if (nes2)
			dirty = 1'b0;
		f.mapper       = {(dirty ? 4'h0 : h[7][7:4]), h[6][7:4]};
		f.prg_size     = size_class(h[4]);
		f.chr_size     = size_class(h[5]);
		f.mirroring    = h[6][0] ^ inv;
		f.has_chr_ram  = (h[5] == 8'h00);
		f.four_screen  = h[6][3];
		f.nes20_mapper = nes2 ? h[8] : 8'h00;
		f.has_saves    = h[6][1];
		return f;
	endfunction

	// Bit that a port shows after n clock pulses, zero once all are out
	function automatic logic serial_bit(input logic [23:0] bits, input int n);
		return (n < PAD_SHIFT_BITS) ? bits[n] : 1'b0;
	endfunction

	// Every write must match the head of the expected queue
	always @(negedge clk) begin : write_monitor
		mem_write_t head;
		if (!reset_nes) begin
			if (downloading)
				assert (mapper_flags == '0)
				else report_mismatch("mapper_flags", 32'd0, mapper_flags);
			if (mem_write) begin
				assert (loader_busy) else fail_run("Memory write while the loader is not busy");
				if (exp_writes.size() == 0) begin
					fail_run($sformatf("Unexpected memory write at address %0h", mem_addr));
				end else begin
					head = exp_writes.pop_front();
					assert (mem_addr == head.addr)
					else report_mismatch("mem_addr", head.addr, mem_addr);
					assert (mem_data == head.data)
					else report_mismatch("mem_data", head.data, mem_data);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic make_header(input byte_t prg, input byte_t chr, input byte_t f6,
	                           input byte_t f7);
		for (int i = 0; i < HEADER_BYTES; i++)
			hdr[i] = 8'h00;
		{hdr[0], hdr[1], hdr[2], hdr[3]} = INES_MAGIC;
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = f6;
		hdr[7] = f7;
	endtask

	task automatic drive_byte(input byte_t b);
		@(posedge clk);
		#2;
		byte_valid = 1'b1;
		byte_data  = b;
	endtask

	task automatic send_header(input byte_t h [HEADER_BYTES]);
		for (int i = 0; i < HEADER_BYTES; i++)
			drive_byte(h[i]);
	endtask

	task automatic send_image(input byte_t h [HEADER_BYTES], input int prg_n,
	                          input int chr_n, input bit expect_writes);
		byte_t b;
		@(posedge clk);
		#2;
		downloading = 1'b1; // One idle cycle before the header
		byte_valid  = 1'b0;
		send_header(h);
		for (int i = 0; i < prg_n + chr_n; i++) begin
			random_byte(b);
			if (expect_writes && i < prg_n)
				exp_writes.push_back({rom_addr_t'(PRG_BASE + i), b});
			else if (expect_writes)
				exp_writes.push_back({rom_addr_t'(CHR_BASE + i - prg_n), b});
			drive_byte(b);
		end
		@(posedge clk);
		#2;
		byte_valid = 1'b0;
		while (loader_done !== 1'b1)
			@(negedge clk);
		assert (exp_writes.size() == 0)
		else fail_run($sformatf("%0d expected memory writes never appeared", exp_writes.size()));
	endtask

	task automatic end_download();
		@(posedge clk);
		#2;
		downloading = 1'b0;
	endtask

	task automatic pulse_joy_clock(input logic [1:0] ports);
		@(posedge clk);
		#2;
		joypad_clock = ports;
		@(posedge clk);
		#2;
		joypad_clock = 2'b00;
		@(posedge clk); // Falling edge seen here
		@(negedge clk);
	endtask

	task automatic check_joypads(input logic tap, input logic swap);
		byte_t       r;
		pad_state_t  first;
		pad_state_t  second;
		logic [23:0] exp_p1;
		logic [23:0] exp_p2;
		logic [1:0]  expected;
		@(posedge clk);
		#2;
		random_byte(r);
		joy_a = r;
		random_byte(r);
		joy_b = r;
		random_byte(r);
		joy_c = r;
		random_byte(r);
		joy_d = r;
		multitap_en   = tap;
		swap_ports    = swap;
		joypad_strobe = 1'b1;
		first  = swap ? joy_b : joy_a;
		second = swap ? joy_a : joy_b;
		exp_p1 = tap ? {MULTITAP_SIG_P1, joy_c, first} : {16'hFFFF, first};
		exp_p2 = tap ? {MULTITAP_SIG_P2, joy_d, second} : {16'hFFFF, second};
		@(posedge clk);
		#2;
		joypad_strobe = 1'b0;
		@(negedge clk);
		for (int i = 0; i < PAD_SHIFT_BITS + 4; i++) begin
			expected = {serial_bit(exp_p2, i), serial_bit(exp_p1, i)};
			assert (joypad_data == expected)
			else report_mismatch($sformatf("joypad_data bit %0d", i), expected, joypad_data);
			pulse_joy_clock(2'b01); // Port 1 moves on, port 2 holds
			expected = {serial_bit(exp_p2, i), serial_bit(exp_p1, i + 1)};
			assert (joypad_data == expected)
			else report_mismatch($sformatf("joypad_data port 1 bit %0d", i + 1), expected,
			                     joypad_data);
			pulse_joy_clock(2'b10);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		mapper_flags_t exp_flags;
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = '0;
		invert_mirroring = 1'b0;
		user_reset       = 1'b0;
		joy_a            = '0;
		joy_b            = '0;
		joy_c            = '0;
		joy_d            = '0;
		multitap_en      = 1'b0;
		swap_ports       = 1'b0;
		joypad_strobe    = 1'b0;
		joypad_clock     = 2'b00;
		repeat (3) @(posedge clk);
		#2;
		reset_nes = 1'b0;

		// Console held in reset until the first download
		repeat (10) begin
			@(negedge clk);
			assert (console_reset) else report_mismatch("console_reset", 1, console_reset);
			assert (!mem_write) else report_mismatch("mem_write", 0, mem_write);
			assert (!loader_busy) else report_mismatch("loader_busy", 0, loader_busy);
			assert (!loader_done) else report_mismatch("loader_done", 0, loader_done);
			assert (joypad_data == 2'b00) else report_mismatch("joypad_data", 0, joypad_data);
		end

		// Valid image, mapper 4 with mirroring
		make_header(8'd1, 8'd1, 8'h41, 8'h00);
		exp_flags = flags_from_header(hdr, 1'b0);
		send_image(hdr, PRG_PAGE_BYTES, CHR_PAGE_BYTES, 1'b1);
		assert (!loader_error) else report_mismatch("loader_error", 0, loader_error);
		end_download();
		repeat (HOLD_CYCLES + 1) begin
			@(negedge clk);
			assert (console_reset) else report_mismatch("console_reset", 1, console_reset);
		end
		@(negedge clk);
		assert (!console_reset) else report_mismatch("console_reset", 0, console_reset);
		assert (mapper_flags == exp_flags)
		else report_mismatch("mapper_flags", exp_flags, mapper_flags);

		@(posedge clk);
		#2;
		user_reset = 1'b1;
		repeat (2) @(negedge clk);
		assert (console_reset) else report_mismatch("console_reset", 1, console_reset);
		@(posedge clk);
		#2;
		user_reset = 1'b0;
		repeat (2) @(negedge clk);
		assert (!console_reset) else report_mismatch("console_reset", 0, console_reset);

		// Dirty header, PRG only, mirroring inverted
		@(posedge clk);
		#2;
		invert_mirroring = 1'b1;
		make_header(8'd1, 8'd0, 8'h13, 8'h20);
		hdr[12] = 8'h5A;
		hdr[13] = 8'hC3;
		exp_flags = flags_from_header(hdr, 1'b1);
		send_image(hdr, PRG_PAGE_BYTES, 0, 1'b1);
		end_download();
		@(negedge clk);
		assert (mapper_flags == exp_flags)
		else report_mismatch("mapper_flags", exp_flags, mapper_flags);
		assert (mapper_flags.mapper == 8'h01)
		else report_mismatch("mapper_flags.mapper", 8'h01, mapper_flags.mapper);
		assert (!mapper_flags.mirroring)
		else report_mismatch("mapper_flags.mirroring", 0, mapper_flags.mirroring);
		@(posedge clk);
		#2;
		invert_mirroring = 1'b0;

		// Bad magic, trailing bytes must not be written
		make_header(8'd1, 8'd1, 8'h41, 8'h00);
		hdr[2] = 8'h5A;
		send_image(hdr, 64, 0, 1'b0);
		assert (loader_error) else report_mismatch("loader_error", 1, loader_error);
		end_download();
		repeat (HOLD_CYCLES * 2) begin
			@(negedge clk);
			assert (console_reset) else report_mismatch("console_reset", 1, console_reset);
		end

		// Joypad ports, all multitap and swap settings
		check_joypads(1'b0, 1'b0);
		check_joypads(1'b1, 1'b0);
		check_joypads(1'b1, 1'b1);
		check_joypads(1'b0, 1'b1);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- source/nes_loader_top.sv
// NES cartridge loader and controller front end
// Connects the ROM loader, the console reset sequencer and the joypad
// serializer
`timescale 1ns/1ps

module nes_loader_top #(
	parameter int DOWNLOAD_HOLD_CYCLES = 255
) (
	input  logic                          clk,
	input  logic                          reset_nes,
	// Host byte stream
	input  logic                          downloading,
	input  logic                          byte_valid,
	input  nes_loader_pkg::byte_t         byte_data,
	input  logic                          invert_mirroring,
	input  logic                          user_reset,
	// Controllers
	input  nes_loader_pkg::pad_state_t    joy_a,
	input  nes_loader_pkg::pad_state_t    joy_b,
	input  nes_loader_pkg::pad_state_t    joy_c,
	input  nes_loader_pkg::pad_state_t    joy_d,
	input  logic                          multitap_en,
	input  logic                          swap_ports,
	input  logic                          joypad_strobe,
	input  logic [1:0]                    joypad_clock,
	// ROM memory writes
	output nes_loader_pkg::rom_addr_t     mem_addr,
	output nes_loader_pkg::byte_t         mem_data,
	output logic                          mem_write,
	// Console side
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_busy,
	output logic                          loader_done,
	output logic                          loader_error,
	output logic                          console_reset,
	output logic [1:0]                    joypad_data
);

	rom_loader i_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.byte_valid       (byte_valid),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (loader_busy),
		.done             (loader_done),
		.error            (loader_error)
	);

	reset_sequencer #(
		.DOWNLOAD_HOLD_CYCLES (DOWNLOAD_HOLD_CYCLES)
	) i_reset_seq (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (downloading),
		.loader_busy   (loader_busy),
		.loader_error  (loader_error),
		.user_reset    (user_reset),
		.console_reset (console_reset)
	);

	joypad_serializer i_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_c         (joy_c),
		.joy_d         (joy_d),
		.multitap_en   (multitap_en),
		.swap_ports    (swap_ports),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);

endmodule

//--- source/joypad_serializer.sv
// Controller serializer
// Two 24-bit shift registers feeding the console joypad ports, with an
// optional four-player multitap and a port swap
`timescale 1ns/1ps

module joypad_serializer (
	input  logic                       clk,
	input  logic                       reset_nes,
	input  nes_loader_pkg::pad_state_t joy_a,
	input  nes_loader_pkg::pad_state_t joy_b,
	input  nes_loader_pkg::pad_state_t joy_c,
	input  nes_loader_pkg::pad_state_t joy_d,
	input  logic                       multitap_en,
	input  logic                       swap_ports,
	input  logic                       joypad_strobe,
	input  logic [1:0]                 joypad_clock,
	output logic [1:0]                 joypad_data
);
	import nes_loader_pkg::*;

	localparam int PORTS = 2;

	pad_state_t                first_pad;
	pad_state_t                second_pad;
	logic [1:0]                clk_q;        // Port clocks, previous cycle
	logic [PAD_SHIFT_BITS-1:0] load_val [PORTS];
	logic [PAD_SHIFT_BITS-1:0] shift_q  [PORTS];

	//////////////////////////////////////////////////////////////////////
	// Load values

	always_comb begin
		first_pad  = swap_ports ? joy_b : joy_a;
		second_pad = swap_ports ? joy_a : joy_b;

		if (multitap_en) begin
			load_val[0] = {MULTITAP_SIG_P1, joy_c, first_pad};
			load_val[1] = {MULTITAP_SIG_P2, joy_d, second_pad};
		end else begin
			// Without a multitap the extra bits read as ones
			load_val[0] = {{(PAD_SHIFT_BITS - 8){1'b1}}, first_pad};
			load_val[1] = {{(PAD_SHIFT_BITS - 8){1'b1}}, second_pad};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			clk_q <= '0;
			for (int p = 0; p < PORTS; p++)
				shift_q[p] <= '0;
		end else begin
			clk_q <= joypad_clock;
			for (int p = 0; p < PORTS; p++) begin
				if (joypad_strobe)
					shift_q[p] <= load_val[p];
				// Falling clock edge moves the next button to bit 0
				if (!joypad_clock[p] && clk_q[p])
					shift_q[p] <= {1'b0, shift_q[p][PAD_SHIFT_BITS-1:1]};
			end
		end
	end

	assign joypad_data = {shift_q[1][0], shift_q[0][0]};

endmodule

//--- source/reset_sequencer.sv
// Console reset sequencer
// Holds the console in reset until the first download, stretches reset
// after each download and while the loader reports an error
`timescale 1ns/1ps

module reset_sequencer #(
	parameter int DOWNLOAD_HOLD_CYCLES = 255
) (
	input  logic clk,
	input  logic reset_nes,
	input  logic downloading,
	input  logic loader_busy,
	input  logic loader_error,
	input  logic user_reset,
	output logic console_reset
);

	localparam int CNT_W = $clog2(DOWNLOAD_HOLD_CYCLES + 1);

	logic             seen_download_q; // Set by the first download
	logic [CNT_W-1:0] hold_cnt_q;

	// Hold counter, paused while the loader is still writing
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			hold_cnt_q <= '0;
		end else if (downloading) begin
			hold_cnt_q <= CNT_W'(DOWNLOAD_HOLD_CYCLES);
		end else if (!loader_busy && hold_cnt_q != '0) begin
			hold_cnt_q <= hold_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			seen_download_q <= 1'b0;
			console_reset   <= 1'b1;
		end else begin
			if (downloading)
				seen_download_q <= 1'b1;
			console_reset <= ~seen_download_q
			               | (hold_cnt_q != '0)
			               | loader_error
			               | user_reset;
		end
	end

endmodule

//--- source/rom_loader.sv
// iNES ROM loader
// Takes the host byte stream, checks the header and places the PRG and
// CHR pages in ROM memory, then latches the mapper flags
`timescale 1ns/1ps

module rom_loader (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          downloading,
	input  logic                          byte_valid,
	input  nes_loader_pkg::byte_t         byte_data,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::rom_addr_t     mem_addr,
	output nes_loader_pkg::byte_t         mem_data,
	output logic                          mem_write,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          busy,
	output logic                          done,
	output logic                          error
);
	import nes_loader_pkg::*;

	localparam logic [3:0] LAST_HDR = 4'(HEADER_BYTES - 1);

	loader_state_t state_q;
	logic          dl_q;
	logic          dl_rise;
	logic          take;
	logic          hdr_take;
	logic [3:0]    hdr_cnt_q;
	logic [3:0]    hdr_index;
	rom_addr_t     addr_q;
	byte_count_t   count_q;
	byte_count_t   prg_bytes;
	byte_count_t   chr_bytes;
	mapper_flags_t flags_q;

	logic          header_ok;
	logic          header_trainer;
	byte_t         prg_pages;
	byte_t         chr_pages;
	mapper_flags_t parsed_flags;

	assign dl_rise = downloading & ~dl_q;
	assign take    = byte_valid & downloading;

	// A byte arriving with the download edge is header byte 0
	assign hdr_take  = take & (dl_rise | (state_q == LOAD_HEADER));
	assign hdr_index = dl_rise ? 4'd0 : hdr_cnt_q;

	ines_header_parser i_parser (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.header_wr        (hdr_take),
		.header_index     (hdr_index),
		.header_byte      (byte_data),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.header_trainer   (header_trainer),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (parsed_flags)
	);

	assign prg_bytes = byte_count_t'(prg_pages) * byte_count_t'(PRG_PAGE_BYTES);
	assign chr_bytes = byte_count_t'(chr_pages) * byte_count_t'(CHR_PAGE_BYTES);

	// Write path is combinational, data goes out with its strobe
	assign mem_addr  = addr_q;
	assign mem_data  = byte_data;
	assign mem_write = take & ~dl_rise & (count_q != '0)
	                 & ((state_q == LOAD_PRG) | (state_q == LOAD_CHR));

	assign mapper_flags = downloading ? '0 : flags_q; // Console sees no mapper while loading

	//////////////////////////////////////////////////////////////////////
	// Download FSM

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state_q   <= LOAD_HEADER;
			dl_q      <= 1'b0;
			hdr_cnt_q <= '0;
			addr_q    <= PRG_BASE;
			count_q   <= '0;
			flags_q   <= '0;
			busy      <= 1'b0;
			done      <= 1'b0;
			error     <= 1'b0;
		end else begin
			dl_q <= downloading;
			if (dl_rise) begin
				state_q   <= LOAD_HEADER;
				hdr_cnt_q <= byte_valid ? 4'd1 : 4'd0;
				flags_q   <= '0;
				busy      <= 1'b0;
				done      <= 1'b0;
				error     <= 1'b0;
			end else begin
				case (state_q)
					LOAD_HEADER: if (take) begin
						hdr_cnt_q <= hdr_cnt_q + 4'd1;
						if (hdr_cnt_q == LAST_HDR) begin
							// Trainers are not supported
							if (header_ok && !header_trainer) begin
								state_q <= LOAD_PRG;
								busy    <= 1'b1;
								addr_q  <= PRG_BASE;
								count_q <= prg_bytes;
							end else begin
								state_q <= LOAD_ERROR;
								done    <= 1'b1;
								error   <= 1'b1;
								flags_q <= parsed_flags;
							end
						end
					end
					LOAD_PRG, LOAD_CHR: begin
						if (take && count_q != '0) begin
							addr_q  <= addr_q + 1'b1;
							count_q <= count_q - 1'b1;
						end
						// Section ends on its last byte, or at once when empty
						if (count_q == '0 || (take && count_q == byte_count_t'(1))) begin
							if (state_q == LOAD_PRG) begin
								state_q <= LOAD_CHR;
								addr_q  <= CHR_BASE;
								count_q <= chr_bytes;
							end else begin
								state_q <= LOAD_DONE;
								busy    <= 1'b0;
								done    <= 1'b1;
								flags_q <= parsed_flags;
							end
						end
					end
					default: ; // Error and done ignore further bytes
				endcase
			end
		end
	end

endmodule

//--- source/ines_header_parser.sv
// iNES header parser
// Stores the 16 header bytes and derives the magic check, trainer bit,
// page counts and the mapper flags word
`timescale 1ns/1ps

module ines_header_parser (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          header_wr,
	input  logic [3:0]                    header_index,
	input  nes_loader_pkg::byte_t         header_byte,
	input  logic                          invert_mirroring,
	output logic                          header_ok,
	output logic                          header_trainer,
	output nes_loader_pkg::byte_t         prg_pages,
	output nes_loader_pkg::byte_t         chr_pages,
	output nes_loader_pkg::mapper_flags_t flags
);
	import nes_loader_pkg::*;

	byte_t hdr_q [HEADER_BYTES];
	logic  is_nes20;
	logic  is_dirty;

	// Smallest power-of-two class that holds the page count
	function automatic size_code_t size_code(input byte_t pages);
		size_code_t code;
		if      (pages <= 8'd1)  code = 3'd0;
		else if (pages <= 8'd2)  code = 3'd1;
		else if (pages <= 8'd4)  code = 3'd2;
		else if (pages <= 8'd8)  code = 3'd3;
		else if (pages <= 8'd16) code = 3'd4;
		else if (pages <= 8'd32) code = 3'd5;
		else if (pages <= 8'd64) code = 3'd6;
		else                     code = 3'd7;
		return code;
	endfunction

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			for (int i = 0; i < HEADER_BYTES; i++)
				hdr_q[i] <= '0;
		end else if (header_wr) begin
			hdr_q[header_index] <= header_byte;
		end
	end

	assign header_ok      = ({hdr_q[0], hdr_q[1], hdr_q[2], hdr_q[3]} == INES_MAGIC);
	assign header_trainer = hdr_q[6][2];
	assign prg_pages      = hdr_q[4]; // 16 KiB pages
	assign chr_pages      = hdr_q[5]; // 8 KiB pages, zero means CHR RAM

	assign is_nes20 = (hdr_q[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail of the header
	always_comb begin
		is_dirty = (hdr_q[9][7:1] != 7'd0);
		for (int i = 10; i < HEADER_BYTES; i++)
			is_dirty = is_dirty | (hdr_q[i] != 8'd0);
		is_dirty = is_dirty & ~is_nes20;
	end

	always_comb begin
		flags              = '0;
		flags.mapper       = {is_dirty ? 4'b0000 : hdr_q[7][7:4], hdr_q[6][7:4]};
		flags.prg_size     = size_code(prg_pages);
		flags.chr_size     = size_code(chr_pages);
		flags.mirroring    = hdr_q[6][0] ^ invert_mirroring;
		flags.has_chr_ram  = (chr_pages == 8'd0);
		flags.four_screen  = hdr_q[6][3];
		flags.nes20_mapper = is_nes20 ? hdr_q[8] : 8'h00;
		flags.has_saves    = hdr_q[6][1]; // Battery backed RAM
	end

endmodule

//--- source/nes_loader_pkg.sv
// NES loader package
// Shared types, iNES header constants and the ROM memory map used by the
// cartridge loader and the controller serializer
package nes_loader_pkg;

	typedef logic [7:0]  byte_t;       // Stream and memory data byte
	typedef logic [21:0] rom_addr_t;   // ROM byte address
	typedef logic [21:0] byte_count_t; // Bytes left to load
	typedef logic [2:0]  size_code_t;  // log2 size class of ROM pages

	// Mapper flags word handed to the console, low bits at the bottom
	typedef struct packed {
		logic [5:0] reserved;     // Always zero
		logic       has_saves;
		byte_t      nes20_mapper;
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	// Controller buttons, bit 0 is shifted out first
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;
	} pad_state_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} loader_state_t;

	//////////////////////////////////////////////////////////////////////
	// iNES format and memory map

	localparam logic [31:0] INES_MAGIC = {8'h4E, 8'h45, 8'h53, 8'h1A}; // "NES" 1A
	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;

	localparam rom_addr_t PRG_BASE = 22'h000000;
	localparam rom_addr_t CHR_BASE = 22'h200000;

	// Multitap signature bytes, sent after the third and fourth pad
	localparam byte_t MULTITAP_SIG_P1 = 8'h08;
	localparam byte_t MULTITAP_SIG_P2 = 8'h04;
	localparam int    PAD_SHIFT_BITS  = 24;

endpackage
